/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pwm_burst_tb -Mdir obj_dir -f pwm_burst.f
	./obj_dir/Vpwm_burst_tb | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/pwm_burst_seq.sv */
module pwm_burst_seq (
    input  logic      clk,
    input  logic      rst_n,
    pwm_cfg_if.seq    cfg,
    pwm_stat_if.seq   stat,
    output logic      pwm,
    output logic      period_tick,
    output logic      burst_done
);

    pwm_cfg_pkg::seq_state_t  state_q;
    pwm_cfg_pkg::seq_state_t  state_d;
    pwm_cfg_pkg::phase_t      high_q;
    pwm_cfg_pkg::phase_t      low_q;
    pwm_cfg_pkg::repeat_t     repeat_q;
    pwm_cfg_pkg::repeat_t     rep_cnt_q;
    pwm_cfg_pkg::phase_t      cnt_load_value;
    logic                     cnt_load;
    logic                     terminal;
    logic                     period_end;
    logic                     last_period;

    assign last_period = (rep_cnt_q == repeat_q);

    // The load cycle is the first cycle of a phase, so the counter takes
    // length-1 and a zero length skips the run state.
    always_comb begin
        state_d        = state_q;
        cnt_load       = 1'b0;
        cnt_load_value = low_q - pwm_cfg_pkg::phase_t'(1);
        period_end     = 1'b0;
        case (state_q)
            pwm_cfg_pkg::SEQ_IDLE: begin
                if (cfg.start) begin
                    state_d = pwm_cfg_pkg::SEQ_HIGH_LOAD;
                end
            end
            pwm_cfg_pkg::SEQ_HIGH_LOAD: begin
                cnt_load       = 1'b1;
                cnt_load_value = high_q - pwm_cfg_pkg::phase_t'(1);
                state_d = (high_q == '0) ? pwm_cfg_pkg::SEQ_LOW_LOAD : pwm_cfg_pkg::SEQ_HIGH_RUN;
            end
            pwm_cfg_pkg::SEQ_HIGH_RUN: begin
                if (terminal) begin
                    state_d = pwm_cfg_pkg::SEQ_LOW_LOAD;
                end
            end
            pwm_cfg_pkg::SEQ_LOW_LOAD: begin
                cnt_load = 1'b1;
                if (low_q == '0) begin
                    period_end = 1'b1;
                end else begin
                    state_d = pwm_cfg_pkg::SEQ_LOW_RUN;
                end
            end
            pwm_cfg_pkg::SEQ_LOW_RUN: begin
                period_end = terminal;
            end
            default: state_d = pwm_cfg_pkg::SEQ_IDLE;
        endcase
        if (period_end) begin
            state_d = last_period ? pwm_cfg_pkg::SEQ_IDLE : pwm_cfg_pkg::SEQ_HIGH_LOAD;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= pwm_cfg_pkg::SEQ_IDLE;
            rep_cnt_q <= '0;
            pwm       <= 1'b0;
        end else begin
            state_q <= state_d;
            // Output lags the state by one cycle.
            pwm     <= (state_q == pwm_cfg_pkg::SEQ_HIGH_LOAD) ||
                       (state_q == pwm_cfg_pkg::SEQ_HIGH_RUN);
            if (state_q == pwm_cfg_pkg::SEQ_IDLE) begin
                rep_cnt_q <= '0;
            end else if (period_end && !last_period) begin
                rep_cnt_q <= rep_cnt_q + pwm_cfg_pkg::repeat_t'(1);
            end
        end
    end

    // Configuration sampled at start.
    always_ff @(posedge clk) begin
        if (state_q == pwm_cfg_pkg::SEQ_IDLE && cfg.start) begin
            high_q   <= cfg.high_count;
            low_q    <= cfg.low_count;
            repeat_q <= cfg.repeat_count;
        end
    end

    pwm_phase_counter u_phase_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (cnt_load),
        .load_value (cnt_load_value),
        .count      (),
        .terminal   (terminal)
    );

    assign period_tick = period_end;
    assign burst_done  = period_end && last_period;
    assign stat.busy   = (state_q != pwm_cfg_pkg::SEQ_IDLE);

endmodule

/* hdl/pwm_burst_status.sv */
module pwm_burst_status (
    input  logic         clk,
    input  logic         rst_n,
    pwm_stat_if.status   stat,
    input  logic         period_tick,
    input  logic         burst_done,
    input  logic         start_seen,
    output logic         irq
);

    pwm_cfg_pkg::period_cnt_t period_q;
    logic                     done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_q <= '0;
        end else if (start_seen) begin
            period_q <= '0;
        end else if (period_tick) begin
            period_q <= period_q + pwm_cfg_pkg::period_cnt_t'(1);
        end
    end

    // Sticky, a new done beats a clear in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (burst_done) begin
            done_q <= 1'b1;
        end else if (stat.done_clear) begin
            done_q <= 1'b0;
        end
    end

    assign stat.period_count = period_q;
    assign stat.done_flag    = done_q;
    assign irq               = done_q && stat.irq_en;

endmodule

/* hdl/pwm_burst_top.sv */
module pwm_burst_top (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                awvalid,
    output logic                awready,
    input  pwm_bus_pkg::addr_t  awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  pwm_bus_pkg::data_t  wdata,
    input  pwm_bus_pkg::strb_t  wstrb,
    output logic                bvalid,
    input  logic                bready,
    output pwm_bus_pkg::resp_t  bresp,
    input  logic                arvalid,
    output logic                arready,
    input  pwm_bus_pkg::addr_t  araddr,
    output logic                rvalid,
    input  logic                rready,
    output pwm_bus_pkg::data_t  rdata,
    output pwm_bus_pkg::resp_t  rresp,

    output logic                pwm,
    output logic                irq
);

    logic period_tick;
    logic burst_done;

    pwm_cfg_if  cfg_bus ();
    pwm_stat_if stat_bus ();

    pwm_reg_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .cfg     (cfg_bus.ctrl),
        .stat    (stat_bus.regs)
    );

    pwm_burst_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_bus.seq),
        .stat        (stat_bus.seq),
        .pwm         (pwm),
        .period_tick (period_tick),
        .burst_done  (burst_done)
    );

    // Period count restarts with every accepted start.
    pwm_burst_status u_status (
        .clk         (clk),
        .rst_n       (rst_n),
        .stat        (stat_bus.status),
        .period_tick (period_tick),
        .burst_done  (burst_done),
        .start_seen  (cfg_bus.start),
        .irq         (irq)
    );

endmodule

/* hdl/pwm_bus_pkg.sv */
package pwm_bus_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // AXI4-Lite response codes.
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* hdl/pwm_cfg_pkg.sv */
package pwm_cfg_pkg;

    // Field widths of the burst configuration.
    localparam int PHASE_W  = 8;
    localparam int REPEAT_W = 8;
    localparam int PERIOD_W = 16;

    // Phase length, the real phase is value+1 cycles.
    typedef logic [PHASE_W-1:0]  phase_t;
    // Burst has value+1 periods.
    typedef logic [REPEAT_W-1:0] repeat_t;
    typedef logic [PERIOD_W-1:0] period_cnt_t;

    // Register map, byte offsets.
    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_HIGH    = 8'h04;
    localparam logic [7:0] REG_LOW     = 8'h08;
    localparam logic [7:0] REG_REPEAT  = 8'h0C;
    localparam logic [7:0] REG_STATUS  = 8'h10;
    localparam logic [7:0] REG_PERIODS = 8'h14;

    // Bit positions inside CTRL and STATUS.
    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;
    localparam int STAT_BUSY_BIT   = 0;
    localparam int STAT_DONE_BIT   = 1;

    typedef enum logic [2:0] {
        SEQ_IDLE      = 3'd0,
        SEQ_HIGH_LOAD = 3'd1,
        SEQ_HIGH_RUN  = 3'd2,
        SEQ_LOW_LOAD  = 3'd3,
        SEQ_LOW_RUN   = 3'd4
    } seq_state_t;

endpackage

/* hdl/pwm_ctrl_if.sv */
// Burst configuration from the register file to the sequencer.
interface pwm_cfg_if;

    logic                  start;
    pwm_cfg_pkg::phase_t   high_count;
    pwm_cfg_pkg::phase_t   low_count;
    pwm_cfg_pkg::repeat_t  repeat_count;

    modport ctrl (
        output start, high_count, low_count, repeat_count
    );

    modport seq (
        input  start, high_count, low_count, repeat_count
    );

endinterface

// Status exchange between register file, sequencer and result stage.
interface pwm_stat_if;

    logic                      busy;
    logic                      done_flag;
    pwm_cfg_pkg::period_cnt_t  period_count;
    logic                      done_clear;
    logic                      irq_en;

    modport regs (
        input  busy, done_flag, period_count,
        output done_clear, irq_en
    );

    modport status (
        input  done_clear, irq_en,
        output done_flag, period_count
    );

    modport seq (
        output busy
    );

endinterface

/* hdl/pwm_phase_counter.sv */
module pwm_phase_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  pwm_cfg_pkg::phase_t  load_value,
    output pwm_cfg_pkg::phase_t  count,
    output logic                 terminal
);

    pwm_cfg_pkg::phase_t count_q;

    // Down counter, parks at zero until the next load.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= load_value;
        end else if (count_q != '0) begin
            count_q <= count_q - pwm_cfg_pkg::phase_t'(1);
        end
    end

    assign count    = count_q;
    assign terminal = (count_q == '0);

endmodule

/* hdl/pwm_reg_decode.sv */
module pwm_reg_decode (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                awvalid,
    output logic                awready,
    input  pwm_bus_pkg::addr_t  awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  pwm_bus_pkg::data_t  wdata,
    input  pwm_bus_pkg::strb_t  wstrb,
    output logic                bvalid,
    input  logic                bready,
    output pwm_bus_pkg::resp_t  bresp,
    input  logic                arvalid,
    output logic                arready,
    input  pwm_bus_pkg::addr_t  araddr,
    output logic                rvalid,
    input  logic                rready,
    output pwm_bus_pkg::data_t  rdata,
    output pwm_bus_pkg::resp_t  rresp,

    pwm_cfg_if.ctrl             cfg,
    pwm_stat_if.regs            stat
);

    pwm_cfg_pkg::phase_t   high_q;
    pwm_cfg_pkg::phase_t   low_q;
    pwm_cfg_pkg::repeat_t  repeat_q;
    logic                  irq_en_q;
    logic                  start_q;
    logic                  done_clear_q;
    logic                  wr_fire;
    logic                  wr_en;
    logic                  rd_fire;
    pwm_bus_pkg::data_t    rd_data;

    function automatic logic is_mapped(pwm_bus_pkg::addr_t addr);
        return addr inside {pwm_cfg_pkg::REG_CTRL, pwm_cfg_pkg::REG_HIGH,
                            pwm_cfg_pkg::REG_LOW, pwm_cfg_pkg::REG_REPEAT,
                            pwm_cfg_pkg::REG_STATUS, pwm_cfg_pkg::REG_PERIODS};
    endfunction

    assign wr_fire = awvalid && awready && wvalid && wready;
    // Only the low byte carries register bits.
    assign wr_en   = wr_fire && wstrb[0] && is_mapped(awaddr);
    assign rd_fire = arvalid && arready;

    // AW and W are taken together, never while a response is pending.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awready) begin
                awready <= 1'b0;
                wready  <= 1'b0;
            end else if (awvalid && wvalid && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= is_mapped(awaddr) ? pwm_bus_pkg::RESP_OKAY : pwm_bus_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            high_q       <= '0;
            low_q        <= '0;
            repeat_q     <= '0;
            irq_en_q     <= 1'b0;
            start_q      <= 1'b0;
            done_clear_q <= 1'b0;
        end else begin
            start_q      <= 1'b0;
            done_clear_q <= 1'b0;
            if (wr_en) begin
                case (awaddr)
                    pwm_cfg_pkg::REG_CTRL: begin
                        irq_en_q <= wdata[pwm_cfg_pkg::CTRL_IRQ_EN_BIT];
                        // A start during a burst is dropped.
                        start_q  <= wdata[pwm_cfg_pkg::CTRL_START_BIT] && !stat.busy;
                    end
                    pwm_cfg_pkg::REG_HIGH:   high_q   <= wdata[pwm_cfg_pkg::PHASE_W-1:0];
                    pwm_cfg_pkg::REG_LOW:    low_q    <= wdata[pwm_cfg_pkg::PHASE_W-1:0];
                    pwm_cfg_pkg::REG_REPEAT: repeat_q <= wdata[pwm_cfg_pkg::REPEAT_W-1:0];
                    pwm_cfg_pkg::REG_STATUS: done_clear_q <= wdata[pwm_cfg_pkg::STAT_DONE_BIT];
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (araddr)
            pwm_cfg_pkg::REG_CTRL:    rd_data[pwm_cfg_pkg::CTRL_IRQ_EN_BIT] = irq_en_q;
            pwm_cfg_pkg::REG_HIGH:    rd_data = pwm_bus_pkg::data_t'(high_q);
            pwm_cfg_pkg::REG_LOW:     rd_data = pwm_bus_pkg::data_t'(low_q);
            pwm_cfg_pkg::REG_REPEAT:  rd_data = pwm_bus_pkg::data_t'(repeat_q);
            pwm_cfg_pkg::REG_STATUS: begin
                rd_data[pwm_cfg_pkg::STAT_BUSY_BIT] = stat.busy;
                rd_data[pwm_cfg_pkg::STAT_DONE_BIT] = stat.done_flag;
            end
            pwm_cfg_pkg::REG_PERIODS: rd_data = pwm_bus_pkg::data_t'(stat.period_count);
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (arready) begin
                arready <= 1'b0;
            end else if (arvalid && !rvalid) begin
                arready <= 1'b1;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read data held until rready.
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= is_mapped(araddr) ? pwm_bus_pkg::RESP_OKAY : pwm_bus_pkg::RESP_SLVERR;
        end
    end

    assign cfg.start        = start_q;
    assign cfg.high_count   = high_q;
    assign cfg.low_count    = low_q;
    assign cfg.repeat_count = repeat_q;
    assign stat.done_clear  = done_clear_q;
    assign stat.irq_en      = irq_en_q;

endmodule

/* pwm_burst.f */
hdl/pwm_cfg_pkg.sv
hdl/pwm_bus_pkg.sv
hdl/pwm_ctrl_if.sv
hdl/pwm_phase_counter.sv
hdl/pwm_reg_decode.sv
hdl/pwm_burst_seq.sv
hdl/pwm_burst_status.sv
hdl/pwm_burst_top.sv
verif/tb_clock_gen.sv
verif/pwm_burst_tb.sv

/* verif/pwm_burst_tb.sv */
module pwm_burst_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 100;
    localparam int POLL_LIMIT = 500;

    logic clk;
    logic rst_n;
    logic awvalid;
    logic awready;
    pwm_bus_pkg::addr_t awaddr;
    logic wvalid;
    logic wready;
    pwm_bus_pkg::data_t wdata;
    pwm_bus_pkg::strb_t wstrb;
    logic bvalid;
    logic bready;
    pwm_bus_pkg::resp_t bresp;
    logic arvalid;
    logic arready;
    pwm_bus_pkg::addr_t araddr;
    logic rvalid;
    logic rready;
    pwm_bus_pkg::data_t rdata;
    pwm_bus_pkg::resp_t rresp;
    logic pwm;
    logic irq;

    int mismatch_count;
    int timeout_count;
    logic pwm_prev;
    int run_len;
    int high_pulses;
    int exp_high_len;
    int exp_low_len;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    pwm_burst_top DUT (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .pwm(pwm), .irq(irq)
    );

    // Pending responses hold still until the master takes them.
    bresp_held: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
        mismatch_count++;
        $display("mismatch bvalid/bresp under back-pressure: bvalid=%h bresp=%h", bvalid, bresp);
    end

    rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
        mismatch_count++;
        $display("mismatch rvalid/rdata/rresp under back-pressure: rvalid=%h rdata=%h rresp=%h",
                 rvalid, rdata, rresp);
    end

    // Run length monitor on pwm.
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (pwm === pwm_prev) begin
                run_len++;
            end else begin
                if (pwm_prev) begin
                    high_pulses++;
                    assert (run_len == exp_high_len) else begin
                        mismatch_count++;
                        $display("mismatch pwm high run: got %h, expected %h", run_len, exp_high_len);
                    end
                end else if (high_pulses > 0) begin
                    assert (run_len == exp_low_len) else begin
                        mismatch_count++;
                        $display("mismatch pwm low run: got %h, expected %h", run_len, exp_low_len);
                    end
                end
                run_len = 1;
            end
            pwm_prev = pwm;
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic axi_write(input pwm_bus_pkg::addr_t addr, input pwm_bus_pkg::data_t data,
                             input int hold, output pwm_bus_pkg::resp_t resp);
        int t;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        t = 0;
        @(negedge clk);
        while (!(awready && wready) && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!(awready && wready)) report_timeout("awready and wready");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        t = 0;
        while (!bvalid && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!bvalid) report_timeout("bvalid");
        resp = bresp;
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input pwm_bus_pkg::addr_t addr, input int hold,
                            output pwm_bus_pkg::data_t data, output pwm_bus_pkg::resp_t resp);
        int t;
        araddr  = addr;
        arvalid = 1'b1;
        t = 0;
        @(negedge clk);
        while (!arready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!arready) report_timeout("arready");
        @(negedge clk);
        arvalid = 1'b0;
        t = 0;
        while (!rvalid && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!rvalid) report_timeout("rvalid");
        data = rdata;
        resp = rresp;
        repeat (hold) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_register_access();
        pwm_bus_pkg::resp_t resp;
        pwm_bus_pkg::data_t rd;
        pwm_bus_pkg::data_t high_v;
        high_v = pwm_bus_pkg::data_t'($urandom_range(255, 0));
        axi_write(pwm_cfg_pkg::REG_HIGH, high_v, $urandom_range(6, 1), resp);
        expect_equal("bresp HIGH", 32'(resp), 32'(pwm_bus_pkg::RESP_OKAY));
        axi_write(pwm_cfg_pkg::REG_LOW, 32'h0000_00A5, $urandom_range(6, 1), resp);
        axi_write(pwm_cfg_pkg::REG_REPEAT, 32'h0000_003C, 0, resp);
        axi_read(pwm_cfg_pkg::REG_HIGH, $urandom_range(6, 1), rd, resp);
        expect_equal("rdata HIGH", rd, high_v);
        expect_equal("rresp HIGH", 32'(resp), 32'(pwm_bus_pkg::RESP_OKAY));
        axi_read(pwm_cfg_pkg::REG_LOW, $urandom_range(6, 1), rd, resp);
        expect_equal("rdata LOW", rd, 32'h0000_00A5);
        axi_read(pwm_cfg_pkg::REG_REPEAT, 0, rd, resp);
        expect_equal("rdata REPEAT", rd, 32'h0000_003C);
        expect_equal("rresp REPEAT", 32'(resp), 32'(pwm_bus_pkg::RESP_OKAY));
        // Unmapped offset.
        axi_write(8'h20, 32'hFFFF_FFFF, $urandom_range(6, 1), resp);
        expect_equal("bresp 0x20", 32'(resp), 32'(pwm_bus_pkg::RESP_SLVERR));
        axi_read(8'h20, $urandom_range(6, 1), rd, resp);
        expect_equal("rresp 0x20", 32'(resp), 32'(pwm_bus_pkg::RESP_SLVERR));
        axi_read(pwm_cfg_pkg::REG_CTRL, 0, rd, resp);
        expect_equal("rdata CTRL after 0x20 write", rd, 32'h0000_0000);
    endtask

    task automatic run_burst(input int high_val, input int low_val, input int rep_val,
                             input logic irq_on, input logic restart_mid);
        pwm_bus_pkg::resp_t resp;
        pwm_bus_pkg::data_t rd;
        pwm_bus_pkg::data_t ctrl;
        int t;
        ctrl = pwm_bus_pkg::data_t'({irq_on, 1'b1});
        axi_write(pwm_cfg_pkg::REG_HIGH, pwm_bus_pkg::data_t'(high_val), 0, resp);
        axi_write(pwm_cfg_pkg::REG_LOW, pwm_bus_pkg::data_t'(low_val), 0, resp);
        axi_write(pwm_cfg_pkg::REG_REPEAT, pwm_bus_pkg::data_t'(rep_val), 0, resp);
        exp_high_len = high_val + 1;
        exp_low_len  = low_val + 1;
        high_pulses  = 0;
        axi_write(pwm_cfg_pkg::REG_CTRL, ctrl, 0, resp);
        axi_read(pwm_cfg_pkg::REG_STATUS, 0, rd, resp);
        expect_equal("STATUS busy during burst", 32'(rd[0]), 32'd1);
        if (restart_mid) begin
            axi_write(pwm_cfg_pkg::REG_CTRL, ctrl, 0, resp);
        end
        t = 0;
        while (rd[0] && t < POLL_LIMIT) begin
            axi_read(pwm_cfg_pkg::REG_STATUS, 0, rd, resp);
            t++;
        end
        if (rd[0]) report_timeout("end of burst");
        expect_equal("pwm high pulses", 32'(high_pulses), 32'(rep_val + 1));
        expect_equal("STATUS after burst", rd, 32'h0000_0002);
        axi_read(pwm_cfg_pkg::REG_PERIODS, 0, rd, resp);
        expect_equal("PERIODS", rd, 32'(rep_val + 1));
        expect_equal("irq after burst", 32'(irq), 32'(irq_on));
        axi_write(pwm_cfg_pkg::REG_STATUS, 32'h0000_0002, 0, resp);
        axi_read(pwm_cfg_pkg::REG_STATUS, 0, rd, resp);
        expect_equal("STATUS after done clear", rd, 32'h0000_0000);
        expect_equal("irq after done clear", 32'(irq), 32'd0);
    endtask

    initial begin
        int unsigned seed_init;
        int t;
        seed_init = $urandom(32'h6040_dae0);
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        mismatch_count = 0;
        timeout_count  = 0;
        pwm_prev     = 1'b0;
        run_len      = 0;
        high_pulses  = 0;
        exp_high_len = 1;
        exp_low_len  = 1;

        t = 0;
        @(negedge clk);
        while (rst_n !== 1'b1 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (rst_n !== 1'b1) report_timeout("reset release");
        expect_equal("pwm after reset", 32'(pwm), 32'd0);
        expect_equal("irq after reset", 32'(irq), 32'd0);
        expect_equal("bvalid after reset", 32'(bvalid), 32'd0);
        expect_equal("rvalid after reset", 32'(rvalid), 32'd0);
        expect_equal("awready after reset", 32'(awready), 32'd0);
        expect_equal("wready after reset", 32'(wready), 32'd0);
        expect_equal("arready after reset", 32'(arready), 32'd0);

        check_register_access();
        repeat (3) begin
            run_burst($urandom_range(15, 2), $urandom_range(15, 2), $urandom_range(6, 1),
                      1'($urandom_range(1, 0)), 1'b0);
        end
        // Shortest phases in a burst long enough to see busy.
        run_burst(0, 0, 15, 1'b1, 1'b0);
        run_burst(0, 0, 15, 1'b0, 1'b0);
        // Second start lands mid-burst.
        run_burst($urandom_range(15, 4), $urandom_range(15, 4), $urandom_range(6, 3),
                  1'b1, 1'b1);

        $display("Checks done: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for four clock cycles, released on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
